// File: cachePkg.sv
package cachePkg;

   // data words are 16 bits wide, and so is the processor byte address
   localparam int wordWidth = 16;
   localparam int addrWidth = 16;

   // three word-index bits give eight words in every block
   localparam int offsetBits = 3;
   localparam int blockWords = 2 ** offsetBits;

   // default set-index width, which the top level may override
   localparam int setBits = 6;

   // the tag is whatever sits above the set index and the word offset
   // bit 0 of the byte address is dropped since every access is a full word
   localparam int tagBits = addrWidth - setBits - offsetBits - 1;

   // a processor request as the controller captures it
   // the write data travels next to it on its own bus
   typedef struct packed {
      logic [addrWidth-1:0] addr;
      logic                 write;
   } cacheReqT;

   // what one way returns a cycle after a set was presented
   typedef struct packed {
      logic                 valid;
      logic [tagBits-1:0]   tag;
      logic [wordWidth-1:0] word;
   } wayEntryT;

   // the combined view of both ways for the current request
   // victimWay is the set's LRU bit, 0 evicts the even block and 1 the odd one
   typedef struct packed {
      logic                 hit;
      logic                 hitWay;
      logic                 victimWay;
      logic [wordWidth-1:0] word;
   } lookupResultT;

   // controller states, one per clock except where memory ack is awaited
   typedef enum logic [2:0] {
      idle,
      lookup,
      decide,
      fill,
      fillLast,
      writeMem,
      respond
   } ctrlStateT;

endpackage

// File: cacheWay.sv
`timescale 1ns/100ps

module cacheWay #(
   parameter int SET_BITS = cachePkg::setBits
) (
   input  logic                            clk,
   input  logic                            arstN,
   input  logic [SET_BITS-1:0]             rdSet,
   input  logic [SET_BITS-1:0]             wrSet,
   input  logic [cachePkg::offsetBits-1:0] wrWord,
   input  logic [cachePkg::wordWidth-1:0]  wrData,
   input  logic                            wrEn,
   input  logic                            wrValid,
   input  logic [cachePkg::tagBits-1:0]    wrTag,
   input  logic [cachePkg::offsetBits-1:0] rdWord,
   output cachePkg::wayEntryT              entry
);

   localparam int SETS = 2 ** SET_BITS;
   localparam int WORDS = SETS * cachePkg::blockWords;

   // one valid flag per set, kept in flops so reset can clear them all at once
   logic [SETS-1:0] validQ;

   // tag and data storage, plain arrays that map onto RAM
   logic [cachePkg::tagBits-1:0]   tagMem [SETS];
   logic [cachePkg::wordWidth-1:0] dataMem [WORDS];

   // registered read side
   logic                           rdValidQ;
   logic [cachePkg::tagBits-1:0]   rdTagQ;
   logic [cachePkg::wordWidth-1:0] rdWordQ;

   // a data word is addressed as set times eight plus the word index
   logic [SET_BITS+cachePkg::offsetBits-1:0] wrIndex;
   logic [SET_BITS+cachePkg::offsetBits-1:0] rdIndex;

   assign wrIndex = {wrSet, wrWord};
   assign rdIndex = {rdSet, rdWord};

   // a plain word write updates only the data
   // during a refill the tag is rewritten along with every fetched word
   always_ff @(posedge clk) begin
      if (wrEn) begin
         dataMem[wrIndex] <= wrData;
         if (wrValid) begin
            tagMem[wrSet] <= wrTag;
         end
      end
   end

   // the valid bit is raised once a refill begins writing the set
   // nothing in this cache ever invalidates a block again
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         validQ <= '0;
      end else if (wrEn && wrValid) begin
         validQ[wrSet] <= 1'b1;
      end
   end

   // valid is read through a reset flop so no stale hit can show up after reset
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         rdValidQ <= 1'b0;
      end else begin
         rdValidQ <= validQ[rdSet];
      end
   end

   // tag and word arrive one clock after the set is presented
   always_ff @(posedge clk) begin
      rdTagQ  <= tagMem[rdSet];
      rdWordQ <= dataMem[rdIndex];
   end

   assign entry = '{valid: rdValidQ, tag: rdTagQ, word: rdWordQ};

endmodule

// File: waySelect.sv
`timescale 1ns/100ps

module waySelect #(
   parameter int SET_BITS = cachePkg::setBits
) (
   input  logic                         clk,
   input  logic                         arstN,
   input  cachePkg::wayEntryT           way0,
   input  cachePkg::wayEntryT           way1,
   input  logic [cachePkg::tagBits-1:0] reqTag,
   input  logic [SET_BITS-1:0]          lruSet,
   input  logic                         touch,
   input  logic                         touchWay,
   output cachePkg::lookupResultT       result
);

   localparam int SETS = 2 ** SET_BITS;

   // one LRU bit per set, 0 means the even way goes next and 1 the odd way
   logic [SETS-1:0] lruQ;

   // per-way tag match, only meaningful when the way holds a valid block
   logic match0;
   logic match1;

   assign match0 = way0.valid && (way0.tag == reqTag);
   assign match1 = way1.valid && (way1.tag == reqTag);

   // both ways should never match together since a refill only targets a
   // missing tag, but if they do the even way wins
   always_comb begin
      result.hit       = match0 || match1;
      result.hitWay    = !match0 && match1;
      result.victimWay = lruQ[lruSet];
      result.word      = match0 ? way0.word : way1.word;
   end

   // the way just used becomes most recent, so the bit points at the other
   // one. All sets start out evicting the even way
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         lruQ <= '0;
      end else if (touch) begin
         lruQ[lruSet] <= !touchWay;
      end
   end

endmodule

// File: cacheControl.sv
`timescale 1ns/100ps

module cacheControl #(
   parameter int SET_BITS = cachePkg::setBits
) (
   input  logic                            clk,
   input  logic                            arstN,
   input  cachePkg::cacheReqT              req,
   input  logic                            reqValid,
   input  logic [cachePkg::wordWidth-1:0]  reqData,
   input  cachePkg::lookupResultT          result,
   input  logic [cachePkg::wordWidth-1:0]  memDatR,
   input  logic                            memAck,
   output logic                            reqAck,
   output logic [cachePkg::wordWidth-1:0]  rspData,
   output logic                            memCyc,
   output logic                            memStb,
   output logic                            memWe,
   output logic [cachePkg::addrWidth-1:0]  memAdr,
   output logic [cachePkg::wordWidth-1:0]  memDatW,
   output logic [SET_BITS-1:0]             rdSet,
   output logic [SET_BITS-1:0]             wrSet,
   output logic [cachePkg::offsetBits-1:0] wrWord,
   output logic [cachePkg::wordWidth-1:0]  wrData,
   output logic [cachePkg::tagBits-1:0]    wrTag,
   output logic                            wrValid,
   output logic [1:0]                      wrEnWay,
   output logic [cachePkg::tagBits-1:0]    reqTag,
   output logic                            touch,
   output logic                            touchWay
);

   // the byte address is laid out as tag, set, word index, byte bit
   localparam int SET_LSB = cachePkg::offsetBits + 1;

   // fill covers every word but the last, fillLast takes the final one
   localparam logic [cachePkg::offsetBits-1:0] LAST_FILL_WORD =
      cachePkg::offsetBits'(cachePkg::blockWords - 2);

   cachePkg::ctrlStateT state;
   cachePkg::ctrlStateT stateNext;

   // captured request, write data and response word
   cachePkg::cacheReqT             reqQ;
   logic [cachePkg::wordWidth-1:0] dataQ;
   logic [cachePkg::wordWidth-1:0] rspQ;

   // refill bookkeeping
   logic [cachePkg::offsetBits-1:0] wordCntQ;
   logic                            fillWayQ;

   // high for the one clock after a memory ack, which holds stb low between
   // two words of a refill
   logic gapQ;

   logic                            fillPhase;
   logic                            memDone;
   logic [cachePkg::offsetBits-1:0] reqWord;

   assign reqTag  = reqQ.addr[cachePkg::addrWidth-1 -: cachePkg::tagBits];
   assign rdSet   = reqQ.addr[SET_LSB +: SET_BITS];
   assign wrSet   = reqQ.addr[SET_LSB +: SET_BITS];
   assign reqWord = reqQ.addr[1 +: cachePkg::offsetBits];

   // master side, cyc stays up across the whole eight-word refill
   assign fillPhase = (state == cachePkg::fill) || (state == cachePkg::fillLast);
   assign memCyc    = fillPhase || (state == cachePkg::writeMem);
   assign memStb    = memCyc && !gapQ;
   assign memWe     = (state == cachePkg::writeMem);
   assign memDone   = memStb && memAck;
   assign memDatW   = dataQ;

   // refill reads walk the block from its base, a write goes to the word itself
   assign memAdr = memWe ? {reqQ.addr[cachePkg::addrWidth-1:1], 1'b0}
                         : {reqQ.addr[cachePkg::addrWidth-1:SET_LSB], wordCntQ, 1'b0};

   // slave side answers for exactly one clock
   assign reqAck  = (state == cachePkg::respond);
   assign rspData = rspQ;

   // array write port, fed from memory during a refill and from the
   // processor on a write hit
   assign wrWord  = fillPhase ? wordCntQ : reqWord;
   assign wrData  = fillPhase ? memDatR : dataQ;
   assign wrTag   = reqTag;
   assign wrValid = fillPhase;

   always_comb begin
      stateNext = state;
      wrEnWay   = 2'b00;
      touch     = 1'b0;
      touchWay  = fillPhase ? fillWayQ : result.hitWay;
      case (state)
         cachePkg::idle: begin
            if (reqValid) begin
               stateNext = cachePkg::lookup;
            end
         end
         // the arrays are reading the captured set during this clock
         cachePkg::lookup: begin
            stateNext = cachePkg::decide;
         end
         cachePkg::decide: begin
            if (reqQ.write) begin
               // writes never allocate and leave the LRU alone
               wrEnWay[result.hitWay] = result.hit;
               stateNext = cachePkg::writeMem;
            end else if (result.hit) begin
               touch     = 1'b1;
               stateNext = cachePkg::respond;
            end else begin
               stateNext = cachePkg::fill;
            end
         end
         cachePkg::fill: begin
            wrEnWay[fillWayQ] = memDone;
            if (memDone && (wordCntQ == LAST_FILL_WORD)) begin
               stateNext = cachePkg::fillLast;
            end
         end
         cachePkg::fillLast: begin
            wrEnWay[fillWayQ] = memDone;
            if (memDone) begin
               // the refilled way is now the most recent one
               touch     = 1'b1;
               stateNext = cachePkg::respond;
            end
         end
         cachePkg::writeMem: begin
            if (memDone) begin
               stateNext = cachePkg::respond;
            end
         end
         cachePkg::respond: begin
            stateNext = cachePkg::idle;
         end
         default: begin
            stateNext = cachePkg::idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state    <= cachePkg::idle;
         wordCntQ <= '0;
         gapQ     <= 1'b0;
      end else begin
         state <= stateNext;
         gapQ  <= memDone;
         if (state == cachePkg::idle) begin
            wordCntQ <= '0;
         end else if (fillPhase && memDone) begin
            wordCntQ <= wordCntQ + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if ((state == cachePkg::idle) && reqValid) begin
         reqQ  <= req;
         dataQ <= reqData;
      end
      if (state == cachePkg::decide) begin
         fillWayQ <= result.victimWay;
         rspQ     <= result.word;
      end
      // keep the requested word as it streams past during a refill
      if (fillPhase && memDone && (wordCntQ == reqWord)) begin
         rspQ <= memDatR;
      end
   end

endmodule

// File: cacheTop.sv
`timescale 1ns/100ps

module cacheTop #(
   parameter int SET_BITS = cachePkg::setBits
) (
   input  logic                           clk,
   input  logic                           arstN,
   // processor side Wishbone slave
   input  logic                           wbCyc,
   input  logic                           wbStb,
   input  logic                           wbWe,
   input  logic [cachePkg::addrWidth-1:0] wbAdr,
   input  logic [cachePkg::wordWidth-1:0] wbDatW,
   output logic [cachePkg::wordWidth-1:0] wbDatR,
   output logic                           wbAck,
   // memory side Wishbone master
   output logic                           memCyc,
   output logic                           memStb,
   output logic                           memWe,
   output logic [cachePkg::addrWidth-1:0] memAdr,
   output logic [cachePkg::wordWidth-1:0] memDatW,
   input  logic [cachePkg::wordWidth-1:0] memDatR,
   input  logic                           memAck
);

   cachePkg::wayEntryT     entry0;
   cachePkg::wayEntryT     entry1;
   cachePkg::lookupResultT result;

   logic [SET_BITS-1:0]             rdSet;
   logic [SET_BITS-1:0]             wrSet;
   logic [cachePkg::offsetBits-1:0] wrWord;
   logic [cachePkg::wordWidth-1:0]  wrData;
   logic [cachePkg::tagBits-1:0]    wrTag;
   logic                            wrValid;
   logic [1:0]                      wrEnWay;
   logic [cachePkg::tagBits-1:0]    reqTag;
   logic                            touch;
   logic                            touchWay;

   // the slave holds wbAdr steady until ack, so the word index for the
   // array read is taken straight from the bus
   cacheWay #(.SET_BITS(SET_BITS)) way0 (
      .clk(clk), .arstN(arstN), .rdSet(rdSet), .wrSet(wrSet), .wrWord(wrWord),
      .wrData(wrData), .wrEn(wrEnWay[0]), .wrValid(wrValid), .wrTag(wrTag),
      .rdWord(wbAdr[1 +: cachePkg::offsetBits]), .entry(entry0)
   );

   cacheWay #(.SET_BITS(SET_BITS)) way1 (
      .clk(clk), .arstN(arstN), .rdSet(rdSet), .wrSet(wrSet), .wrWord(wrWord),
      .wrData(wrData), .wrEn(wrEnWay[1]), .wrValid(wrValid), .wrTag(wrTag),
      .rdWord(wbAdr[1 +: cachePkg::offsetBits]), .entry(entry1)
   );

   // LRU bits are looked up and updated at the same set the ways read
   waySelect #(.SET_BITS(SET_BITS)) selector (
      .clk(clk), .arstN(arstN), .way0(entry0), .way1(entry1), .reqTag(reqTag),
      .lruSet(rdSet), .touch(touch), .touchWay(touchWay), .result(result)
   );

   cacheControl #(.SET_BITS(SET_BITS)) control (
      .clk(clk), .arstN(arstN),
      .req(cachePkg::cacheReqT'{addr: wbAdr, write: wbWe}),
      .reqValid(wbCyc & wbStb), .reqData(wbDatW), .result(result),
      .memDatR(memDatR), .memAck(memAck), .reqAck(wbAck), .rspData(wbDatR),
      .memCyc(memCyc), .memStb(memStb), .memWe(memWe), .memAdr(memAdr),
      .memDatW(memDatW), .rdSet(rdSet), .wrSet(wrSet), .wrWord(wrWord),
      .wrData(wrData), .wrTag(wrTag), .wrValid(wrValid), .wrEnWay(wrEnWay),
      .reqTag(reqTag), .touch(touch), .touchWay(touchWay)
   );

endmodule

// File: cacheTop_props.sv
`timescale 1ns/100ps

module cacheTop_props (
   input logic                           clk,
   input logic                           arstN,
   input logic                           wbCyc,
   input logic                           wbStb,
   input logic                           wbAck,
   input logic                           memStb,
   input logic                           memWe,
   input logic [cachePkg::addrWidth-1:0] memAdr,
   input logic                           memAck,
   input cachePkg::ctrlStateT            state
);

   // number of failed assertions, read out at the end of a run
   int failCount = 0;

   // the slave ack lasts from one rising edge to the next, so it is
   // compared with cyc and stb in the middle of that clock
   slaveAckInCycle: assert property (@(negedge clk) disable iff (!arstN)
      wbAck |-> (wbCyc && wbStb))
   else begin
      $error("wbAck high without wbCyc and wbStb");
      failCount++;
   end

   // a waiting master keeps strobe, address and direction until ack
   masterHold: assert property (@(posedge clk) disable iff (!arstN)
      (memStb && !memAck) |=> (memStb && $stable(memAdr) && $stable(memWe)))
   else begin
      $error("memory cycle changed before its ack");
      failCount++;
   end

   stateLegal: assert property (@(posedge clk) disable iff (!arstN)
      state inside {cachePkg::idle, cachePkg::lookup, cachePkg::decide, cachePkg::fill,
                    cachePkg::fillLast, cachePkg::writeMem, cachePkg::respond})
   else begin
      $error("controller state outside its encoding");
      failCount++;
   end

endmodule

bind cacheTop cacheTop_props props (
   .clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
   .memStb(memStb), .memWe(memWe), .memAdr(memAdr), .memAck(memAck),
   .state(control.state)
);

// File: cacheTop_tb.sv
`timescale 1ns/100ps

module cacheTop_tb;

   localparam int SET_BITS = 6;
   localparam int SET_LSB = cachePkg::offsetBits + 1;
   localparam int ACK_TIMEOUT = 200;

   // what the current access is expected to do, set when it is issued
   typedef struct packed {
      logic        write;
      logic        hit;
      logic [15:0] addr;
      logic [15:0] data;
   } expectT;

   logic        clk;
   logic        arstN;
   logic        wbCyc;
   logic        wbStb;
   logic        wbWe;
   logic [15:0] wbAdr;
   logic [15:0] wbDatW;
   logic [15:0] wbDatR;
   logic        wbAck;
   logic        memCyc;
   logic        memStb;
   logic        memWe;
   logic [15:0] memAdr;
   logic [15:0] memDatW;
   logic [15:0] memDatR;
   logic        memAck;

   // bus-side backing memory and the shadow copy the reference reads from
   logic [15:0] memory [32768];
   logic [15:0] refMem [32768];

   // reference cache state, two ways per set and one LRU bit
   logic                         modelValid [2**SET_BITS][2];
   logic [cachePkg::tagBits-1:0] modelTag [2**SET_BITS][2];
   logic                         modelLru [2**SET_BITS];

   expectT      expQ;
   logic [15:0] lfsrState;
   logic [15:0] memLfsr;
   time         startTime;
   int          memReads;
   int          memWrites;
   int          errors;
   int          timeouts;
   int          acks;
   int          issued;
   logic        abortRun;

   cacheTop #(.SET_BITS(SET_BITS)) UUT (
      .clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
      .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck), .memCyc(memCyc), .memStb(memStb),
      .memWe(memWe), .memAdr(memAdr), .memDatW(memDatW), .memDatR(memDatR), .memAck(memAck)
   );

   // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one LFSR step per bit taken, newest bit ends up in bit 0
   task automatic drawBits(inout logic [15:0] s, input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         s = lfsrNext(s);
         v = {v[14:0], s[0]};
      end
   endtask

   // every word of memory starts out as a scramble of its full word index
   function automatic logic [15:0] fillWord(input int index);
      return 16'(index * 40503) ^ 16'hC35A;
   endfunction

   function automatic logic [15:0] readRef(input logic [15:0] addr);
      return refMem[addr[15:1]];
   endfunction

   // returns whether the access hits and advances tags, valids and LRU
   // writes neither allocate nor touch the LRU bit
   function automatic logic modelAccess(input logic write, input logic [15:0] addr);
      logic [cachePkg::tagBits-1:0] tag;
      logic [SET_BITS-1:0]          set;
      logic                         hit;
      logic                         way;
      tag = addr[15 -: cachePkg::tagBits];
      set = addr[SET_LSB +: SET_BITS];
      hit = 1'b1;
      way = 1'b0;
      if (modelValid[set][1] && modelTag[set][1] == tag && !(modelValid[set][0] &&
          modelTag[set][0] == tag)) begin
         way = 1'b1;
      end else if (!(modelValid[set][0] && modelTag[set][0] == tag)) begin
         hit = 1'b0;
      end
      if (!write) begin
         if (!hit) begin
            way = modelLru[set];
            modelValid[set][way] = 1'b1;
            modelTag[set][way] = tag;
         end
         modelLru[set] = !way;
      end
      return hit;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         $display("FAIL %s: got %h, expected %h", name, got, want);
         errors++;
      end
   endtask

   // one full slave cycle, held until ack or until the wait runs out
   task automatic access(input logic write, input logic [15:0] addr, input logic [15:0] data);
      int waited;
      if (!abortRun) begin
         @(negedge clk);
         expQ.write = write;
         expQ.addr = addr;
         expQ.hit = modelAccess(write, addr);
         if (write) begin
            refMem[addr[15:1]] = data;
         end
         expQ.data = write ? data : readRef(addr);
         memReads = 0;
         memWrites = 0;
         startTime = $time;
         issued++;
         wbCyc = 1'b1;
         wbStb = 1'b1;
         wbWe = write;
         wbAdr = addr;
         wbDatW = data;
         waited = 0;
         do begin
            @(negedge clk);
            waited++;
         end while (!wbAck && waited < ACK_TIMEOUT);
         if (!wbAck) begin
            $display("timeout: no wbAck within %0d cycles for address %h", ACK_TIMEOUT, addr);
            timeouts++;
            abortRun = 1'b1;
         end
         wbCyc = 1'b0;
         wbStb = 1'b0;
         wbWe = 1'b0;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   // memory slave, acks after 0 to 3 idle cycles and checks every address
   initial begin : backingMemory
      int          delay;
      logic        busy;
      logic [15:0] bits;
      memAck = 1'b0;
      memDatR = '0;
      busy = 1'b0;
      delay = 0;
      forever begin
         @(negedge clk);
         memAck = 1'b0;
         if (arstN && memCyc && memStb) begin
            if (!busy) begin
               drawBits(memLfsr, 2, bits);
               delay = bits;
               busy = 1'b1;
            end
            if (delay == 0) begin
               busy = 1'b0;
               memAck = 1'b1;
               if (memWe) begin
                  checkValue("memAdr", memAdr, {expQ.addr[15:1], 1'b0});
                  checkValue("memDatW", memDatW, expQ.data);
                  memory[memAdr[15:1]] = memDatW;
                  memWrites++;
               end else begin
                  // refill reads walk the block upward from its base
                  checkValue("memAdr", memAdr, {expQ.addr[15:4], 3'(memReads), 1'b0});
                  memDatR = memory[memAdr[15:1]];
                  memReads++;
               end
            end else begin
               delay--;
            end
         end
      end
   end

   // every slave ack is held against the reference prediction
   initial begin : compareAcks
      forever begin
         @(negedge clk);
         if (arstN && wbAck) begin
            acks++;
            if (!expQ.write) begin
               checkValue("wbDatR", wbDatR, expQ.data);
            end
            checkValue("memReads", memReads, (expQ.write || expQ.hit) ? 0 : 8);
            checkValue("memWrites", memWrites, expQ.write ? 1 : 0);
            if (!expQ.write && expQ.hit) begin
               checkValue("hitLatency", 32'(($time - startTime) / 100), 3);
            end
         end
      end
   end

   initial begin : stimulus
      logic [15:0]                  bits;
      logic [15:0]                  data;
      logic [cachePkg::tagBits-1:0] tag;
      logic [SET_BITS-1:0]          set;
      logic                         write;
      arstN = 1'b0;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe = 1'b0;
      wbAdr = '0;
      wbDatW = '0;
      errors = 0;
      timeouts = 0;
      acks = 0;
      issued = 0;
      memReads = 0;
      memWrites = 0;
      abortRun = 1'b0;
      expQ = '0;
      startTime = 0;
      lfsrState = 16'd62894;
      for (int i = 0; i < 32768; i++) begin
         memory[i] = fillWord(i);
         refMem[i] = fillWord(i);
      end
      for (int s = 0; s < 2**SET_BITS; s++) begin
         modelValid[s][0] = 1'b0;
         modelValid[s][1] = 1'b0;
         modelLru[s] = 1'b0;
      end
      // the memory model runs its own sequence, seeded from the main one
      drawBits(lfsrState, 16, memLfsr);
      if (memLfsr == 0) begin
         memLfsr = 16'h0001;
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
      checkValue("wbAck", wbAck, 1'b0);
      checkValue("memCyc", memCyc, 1'b0);
      checkValue("memStb", memStb, 1'b0);

      // cold read, then the same word and a neighbour from its block
      access(1'b0, 16'h1236, '0);
      access(1'b0, 16'h1236, '0);
      access(1'b0, 16'h123A, '0);
      // three tags fighting over set 0x23
      access(1'b0, 16'h5236, '0);
      access(1'b0, 16'h1236, '0);
      access(1'b0, 16'h9236, '0);
      access(1'b0, 16'h1230, '0);
      access(1'b0, 16'h5236, '0);
      // write hit, then write miss, each read back
      access(1'b1, 16'h1236, 16'hBEEF);
      access(1'b0, 16'h1236, '0);
      access(1'b1, 16'h7A50, 16'h1234);
      access(1'b0, 16'h7A50, '0);

      // random mix over four tags and two sets so that blocks keep colliding
      for (int n = 0; n < 400 && !abortRun; n++) begin
         drawBits(lfsrState, 2, bits);
         tag = cachePkg::tagBits'(bits[1:0] * 21 + 3);
         drawBits(lfsrState, 1, bits);
         set = bits[0] ? SET_BITS'(6'h23) : SET_BITS'(6'h05);
         drawBits(lfsrState, 2, bits);
         write = (bits[1:0] == 2'b00);
         drawBits(lfsrState, 3, bits);
         drawBits(lfsrState, 16, data);
         access(write, {tag, set, bits[2:0], 1'b0}, data);
      end

      @(negedge clk);
      checkValue("ackCount", acks, issued);
      $display("closing: %0d mismatches, %0d timeouts, %0d assertion failures",
               errors, timeouts, UUT.props.failCount);
      if (errors == 0 && timeouts == 0 && UUT.props.failCount == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: src.f
cachePkg.sv
cacheWay.sv
waySelect.sv
cacheControl.sv
cacheTop.sv
cacheTop_props.sv
cacheTop_tb.sv

// File: Bender.yml
package:
  name: cache_top

sources:
  # package first, then the RTL from the leaves up to the top level
  - cachePkg.sv
  - cacheWay.sv
  - waySelect.sv
  - cacheControl.sv
  - cacheTop.sv

  # protocol assertions and the testbench
  - target: test
    files:
      - cacheTop_props.sv
      - cacheTop_tb.sv
